//--- Makefile
SRCS := $(shell cat flist.f)

.PHONY: all run clean

all: obj_dir/Vvm16_tb

obj_dir/Vvm16_tb: flist.f $(SRCS)
	verilator --binary --timing --top-module vm16_tb -f flist.f --Mdir obj_dir -o Vvm16_tb

run: obj_dir/Vvm16_tb
	./obj_dir/Vvm16_tb | tee sim.log
	grep -Fqx '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

//--- flist.f
logic/vm16_pkg.sv
logic/vm16_bram.sv
logic/vm16_decode.sv
logic/vm16_alu.sv
logic/vm16_regfile.sv
logic/vm16_mmu.sv
logic/vm16_core.sv
verif/vm16_tb.sv

//--- logic/vm16_alu.sv
// 16-bit unsigned ALU, a is the rd operand and b the ra operand or immediate
// shifts of 16 or more give zero, add and sub wrap
`timescale 1ns/10ps

module vm16_alu (
    input  vm16_pkg::alu_op_t op,
    input  vm16_pkg::word_t   a,
    input  vm16_pkg::word_t   b,
    output vm16_pkg::word_t   c
);
    import vm16_pkg::*;

    always_comb begin
        case (op)
            // moves and load/store addresses just forward b
            alu_pass_b: c = b;
            alu_or:     c = a | b;
            alu_xor:    c = a ^ b;
            alu_and:    c = a & b;
            alu_not:    c = ~b;
            // a shift amount past the word width clears everything
            alu_lshft:  c = a << b;
            alu_rshft:  c = a >> b;
            alu_add:    c = a + b;
            alu_sub:    c = a - b;
            alu_nop:    c = '0;
            alu_bad:    c = '0;
            default:    c = '0;
        endcase
    end

endmodule

//--- logic/vm16_bram.sv
// single-port synchronous RAM, contents start at zero
// read data is registered and holds its old value during a write
`timescale 1ns/10ps

module vm16_bram #(
    parameter int depth = 64
) (
    input  logic                     clk,
    input  logic [$clog2(depth)-1:0] addr,
    input  vm16_pkg::word_t          wdata,
    input  logic                     we,
    output vm16_pkg::word_t          rdata
);
    import vm16_pkg::*;

    word_t mem [depth];

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

//--- logic/vm16_core.sv
// multi-cycle core: fetch, read rd, read ra, memory (LW/SW only), write-back
// the program port is ignored unless reset is high
`timescale 1ns/10ps

module vm16_core (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          prog_we,
    input  logic [vm16_pkg::instr_aw-1:0] prog_addr,
    input  vm16_pkg::word_t               prog_data,
    output logic [7:0]                    pc,
    output vm16_pkg::word_t               paddr,
    output logic                          pwrite,
    output logic                          psel,
    output logic                          penable,
    output vm16_pkg::word_t               pwdata,
    input  vm16_pkg::word_t               prdata,
    input  logic                          pready
);
    import vm16_pkg::*;

    typedef enum logic [2:0] {
        st_fetch,
        st_read_rd,
        st_read_ra,
        st_mem,
        st_wb
    } state_t;

    state_t state;
    logic [7:0] pc_q;
    word_t instr;
    word_t rdd;
    word_t rda;
    word_t mem_word;

    logic imem_we;
    logic [instr_aw-1:0] imem_addr;
    word_t imem_rdata;

    reg_sel_t rd;
    reg_sel_t ra;
    word_t imm8;
    word_t simm5;
    alu_op_t alu_op;
    logic has_imm8;
    logic has_we;
    logic has_mem;
    logic has_mem_we;

    reg_sel_t reg_rs;
    word_t reg_rdata;
    logic reg_we;
    word_t reg_wdata;
    word_t alu_c;

    logic mem_req;
    logic mem_we;
    logic mem_done;
    word_t mem_addr;
    word_t mem_rdata;

    // loader owns the instruction memory while reset is held
    assign imem_we   = prog_we && reset;
    assign imem_addr = imem_we ? prog_addr : pc_q[instr_aw-1:0];
    assign pc        = pc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_fetch;
            pc_q    <= '0;
            instr   <= '0;
            mem_req <= 1'b0;
        end else begin
            mem_req <= 1'b0;
            case (state)
                st_fetch: begin
                    instr <= imem_rdata;
                    // pc sticks at the last instruction slot
                    if (pc_q < 8'(instr_depth - 1)) begin
                        pc_q <= pc_q + 8'd1;
                    end
                    state <= st_read_rd;
                end
                st_read_rd: state <= st_read_ra;
                st_read_ra: begin
                    if (has_mem) begin
                        mem_req <= 1'b1;
                        state   <= st_mem;
                    end else begin
                        state <= st_wb;
                    end
                end
                st_mem: begin
                    if (mem_done) begin
                        state <= st_wb;
                    end
                end
                default: state <= st_fetch;
            endcase
        end
    end

    // operand and load-data registers
    always_ff @(posedge clk) begin
        if (state == st_read_rd) begin
            rdd <= reg_rdata;
        end
        if (state == st_read_ra) begin
            rda <= has_imm8 ? imm8 : reg_rdata;
        end
        if (state == st_mem && mem_done) begin
            mem_word <= mem_rdata;
        end
    end

    assign reg_rs    = (state == st_read_ra) ? ra : rd;
    assign reg_we    = has_we && (state == st_wb);
    assign reg_wdata = has_mem ? mem_word : alu_c;

    // alu passes the ra value through for LW and SW
    assign mem_addr = alu_c + simm5;
    assign mem_we   = has_mem_we && (state == st_mem);

    vm16_bram #(
        .depth (instr_depth)
    ) imem (
        .clk   (clk),
        .addr  (imem_addr),
        .wdata (prog_data),
        .we    (imem_we),
        .rdata (imem_rdata)
    );

    vm16_decode u_decode (
        .instr      (instr),
        .opcode     (),
        .rd         (rd),
        .ra         (ra),
        .imm8       (imm8),
        .simm5      (simm5),
        .alu_op     (alu_op),
        .has_imm8   (has_imm8),
        .has_we     (has_we),
        .has_mem    (has_mem),
        .has_mem_we (has_mem_we)
    );

    vm16_regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .rs    (reg_rs),
        .rdata (reg_rdata),
        .we    (reg_we),
        .ws    (rd),
        .wdata (reg_wdata)
    );

    vm16_alu u_alu (
        .op (alu_op),
        .a  (rdd),
        .b  (rda),
        .c  (alu_c)
    );

    vm16_mmu u_mmu (
        .clk     (clk),
        .reset   (reset),
        .req     (mem_req),
        .addr    (mem_addr),
        .wdata   (rdd),
        .we      (mem_we),
        .done    (mem_done),
        .rdata   (mem_rdata),
        .paddr   (paddr),
        .pwrite  (pwrite),
        .psel    (psel),
        .penable (penable),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

endmodule

//--- logic/vm16_decode.sv
// purely combinational decode of one instruction word
// unknown opcodes decode as a NOP with every flag clear
`timescale 1ns/10ps

module vm16_decode (
    input  vm16_pkg::word_t    instr,
    output vm16_pkg::opcode_t  opcode,
    output vm16_pkg::reg_sel_t rd,
    output vm16_pkg::reg_sel_t ra,
    output vm16_pkg::word_t    imm8,
    output vm16_pkg::word_t    simm5,
    output vm16_pkg::alu_op_t  alu_op,
    output logic               has_imm8,
    output logic               has_we,
    output logic               has_mem,
    output logic               has_mem_we
);
    import vm16_pkg::*;

    logic [4:0] sub_fn;

    assign opcode = opcode_t'(instr[15:11]);
    assign rd     = instr[10:8];
    assign ra     = instr[7:5];
    assign imm8   = {8'h00, instr[7:0]};
    assign simm5  = {11'h000, instr[4:0]};
    assign sub_fn = instr[4:0];

    always_comb begin
        alu_op     = alu_nop;
        has_imm8   = 1'b0;
        has_we     = 1'b0;
        has_mem    = 1'b0;
        has_mem_we = 1'b0;
        case (opcode)
            op_nop: alu_op = alu_nop;
            op_lw: begin
                alu_op  = alu_pass_b;
                has_we  = 1'b1;
                has_mem = 1'b1;
            end
            op_sw: begin
                alu_op     = alu_pass_b;
                has_mem    = 1'b1;
                has_mem_we = 1'b1;
            end
            op_mov: begin
                alu_op = alu_pass_b;
                has_we = 1'b1;
            end
            op_movi: begin
                alu_op   = alu_pass_b;
                has_we   = 1'b1;
                has_imm8 = 1'b1;
            end
            op_bit: begin
                has_we = 1'b1;
                case (sub_fn)
                    bit_or:    alu_op = alu_or;
                    bit_xor:   alu_op = alu_xor;
                    bit_and:   alu_op = alu_and;
                    bit_not:   alu_op = alu_not;
                    bit_lshft: alu_op = alu_lshft;
                    bit_rshft: alu_op = alu_rshft;
                    default:   alu_op = alu_bad;
                endcase
            end
            op_arith_u: begin
                has_we = 1'b1;
                case (sub_fn)
                    arith_add: alu_op = alu_add;
                    arith_sub: alu_op = alu_sub;
                    default:   alu_op = alu_bad;
                endcase
            end
            default: alu_op = alu_nop;
        endcase
    end

endmodule

//--- logic/vm16_mmu.sv
// addr, wdata and we must stay stable from req until done
// scratch accesses finish in one cycle, APB accesses wait on pready
`timescale 1ns/10ps

module vm16_mmu (
    input  logic            clk,
    input  logic            reset,
    input  logic            req,
    input  vm16_pkg::word_t addr,
    input  vm16_pkg::word_t wdata,
    input  logic            we,
    output logic            done,
    output vm16_pkg::word_t rdata,
    output vm16_pkg::word_t paddr,
    output logic            pwrite,
    output logic            psel,
    output logic            penable,
    output vm16_pkg::word_t pwdata,
    input  vm16_pkg::word_t prdata,
    input  logic            pready
);
    import vm16_pkg::*;

    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access
    } apb_state_t;

    apb_state_t apb_state;
    logic tim_sel;
    logic tim_we;
    logic tim_done;
    logic apb_done;
    word_t tim_rdata;
    word_t apb_rdata;

    // the low window of the address map belongs to TIM0
    assign tim_sel = (addr <= tim_last);
    assign tim_we  = req && tim_sel && we;

    vm16_bram #(
        .depth (tim_depth)
    ) tim0 (
        .clk   (clk),
        .addr  (addr[tim_aw-1:0]),
        .wdata (wdata),
        .we    (tim_we),
        .rdata (tim_rdata)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            apb_state <= apb_idle;
            psel      <= 1'b0;
            penable   <= 1'b0;
            pwrite    <= 1'b0;
            tim_done  <= 1'b0;
            apb_done  <= 1'b0;
        end else begin
            tim_done <= req && tim_sel;
            apb_done <= 1'b0;
            case (apb_state)
                apb_idle: begin
                    if (req && !tim_sel) begin
                        psel      <= 1'b1;
                        pwrite    <= we;
                        apb_state <= apb_setup;
                    end
                end
                apb_setup: begin
                    penable   <= 1'b1;
                    apb_state <= apb_access;
                end
                apb_access: begin
                    // wait states simply hold everything
                    if (pready) begin
                        psel      <= 1'b0;
                        penable   <= 1'b0;
                        pwrite    <= 1'b0;
                        apb_done  <= 1'b1;
                        apb_state <= apb_idle;
                    end
                end
                default: apb_state <= apb_idle;
            endcase
        end
    end

    // bus payload, latched at the request and at completion
    always_ff @(posedge clk) begin
        if (apb_state == apb_idle && req && !tim_sel) begin
            paddr  <= addr;
            pwdata <= wdata;
        end
        if (apb_state == apb_access && pready) begin
            apb_rdata <= prdata;
        end
    end

    assign done  = tim_done || apb_done;
    assign rdata = tim_sel ? tim_rdata : apb_rdata;

endmodule

//--- logic/vm16_pkg.sv
// shared widths, depths and encodings of the vm16 core
// scratch memory answers 0x00 to tim_last, every other address goes out over APB
package vm16_pkg;

    localparam int data_width = 16;
    localparam int reg_count = 8;

    // instruction and scratch memory sizes
    localparam int instr_depth = 64;
    localparam int instr_aw = $clog2(instr_depth);
    localparam int tim_depth = 64;
    localparam int tim_aw = $clog2(tim_depth);
    localparam logic [data_width-1:0] tim_last = 16'h003f;

    typedef logic [data_width-1:0] word_t;
    typedef logic [$clog2(reg_count)-1:0] reg_sel_t;

    // major opcode in instr[15:11]
    typedef enum logic [4:0] {
        op_nop     = 5'd0,
        op_lw      = 5'd1,
        op_sw      = 5'd2,
        op_mov     = 5'd3,
        op_movi    = 5'd4,
        op_bit     = 5'd5,
        op_arith_u = 5'd6
    } opcode_t;

    // sub-functions of op_bit, taken from simm5
    localparam logic [4:0] bit_or    = 5'd0;
    localparam logic [4:0] bit_xor   = 5'd1;
    localparam logic [4:0] bit_and   = 5'd2;
    localparam logic [4:0] bit_not   = 5'd3;
    localparam logic [4:0] bit_lshft = 5'd4;
    localparam logic [4:0] bit_rshft = 5'd5;

    // sub-functions of op_arith_u
    localparam logic [4:0] arith_add = 5'd0;
    localparam logic [4:0] arith_sub = 5'd1;

    // operations the ALU knows about
    typedef enum logic [3:0] {
        alu_nop    = 4'd0,
        alu_pass_b = 4'd1,
        alu_or     = 4'd2,
        alu_xor    = 4'd3,
        alu_and    = 4'd4,
        alu_not    = 4'd5,
        alu_lshft  = 4'd6,
        alu_rshft  = 4'd7,
        alu_add    = 4'd8,
        alu_sub    = 4'd9,
        alu_bad    = 4'd10
    } alu_op_t;

endpackage

//--- logic/vm16_regfile.sv
// eight general registers, entry i comes out of reset holding i
`timescale 1ns/10ps

module vm16_regfile (
    input  logic               clk,
    input  logic               reset,
    input  vm16_pkg::reg_sel_t rs,
    output vm16_pkg::word_t    rdata,
    input  logic               we,
    input  vm16_pkg::reg_sel_t ws,
    input  vm16_pkg::word_t    wdata
);
    import vm16_pkg::*;

    word_t regs [reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= word_t'(i);
            end
        end else if (we) begin
            regs[ws] <= wdata;
        end
    end

    // asynchronous read
    assign rdata = regs[rs];

endmodule

//--- verif/vm16_tb.sv
// directed testbench for vm16_core acting as its only APB slave
// programs are loaded through the program port while reset is held high
`timescale 1ns/10ps

module vm16_tb;
    import vm16_pkg::*;

    // opcodes and sub-functions as the instruction set defines them
    localparam logic [4:0] opc_lw = 5'd1;
    localparam logic [4:0] opc_sw = 5'd2;
    localparam logic [4:0] opc_mov = 5'd3;
    localparam logic [4:0] opc_movi = 5'd4;
    localparam logic [4:0] opc_bit = 5'd5;
    localparam logic [4:0] opc_arith = 5'd6;
    localparam logic [4:0] fn_or = 5'd0;
    localparam logic [4:0] fn_xor = 5'd1;
    localparam logic [4:0] fn_and = 5'd2;
    localparam logic [4:0] fn_not = 5'd3;
    localparam logic [4:0] fn_lshft = 5'd4;
    localparam logic [4:0] fn_rshft = 5'd5;
    localparam logic [4:0] fn_add = 5'd0;
    localparam logic [4:0] fn_sub = 5'd1;

    // five tests of 64 load cycles, 10 reset cycles and under 40 instructions
    // of about 12 cycles each stay well below this
    localparam int max_cycles = 5000;

    logic clk = 1'b0;
    logic reset;
    logic prog_we;
    logic [instr_aw-1:0] prog_addr;
    word_t prog_data;
    logic [7:0] pc;
    word_t paddr;
    logic pwrite;
    logic psel;
    logic penable;
    word_t pwdata;
    word_t prdata = 16'h0000;
    logic pready = 1'b0;

    int errors = 0;
    int checks = 0;
    int cycle_count = 0;
    integer seed = 32'hbac2_534d;

    // program image and expected APB transfers of the current test
    word_t prog[$];
    word_t exp_addr[$];
    word_t exp_data[$];
    logic exp_write[$];

    // slave model state written only by the slave process
    word_t slave_mem [16];
    word_t log_addr[$];
    word_t log_data[$];
    logic log_write[$];
    word_t cap_addr;
    word_t cap_wdata;
    logic cap_write;
    logic in_access = 1'b0;
    int waits = 0;
    int min_wait = 0;
    int bus_faults = 0;

    always #50 clk = ~clk;

    vm16_core u_vm16_core (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc        (pc),
        .paddr     (paddr),
        .pwrite    (pwrite),
        .psel      (psel),
        .penable   (penable),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready)
    );

    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // pready set at a falling edge completes the APB transfer at the next rising edge
    always @(negedge clk) begin
        if (pready) begin
            log_addr.push_back(cap_addr);
            log_write.push_back(cap_write);
            log_data.push_back(cap_write ? cap_wdata : prdata);
            pready = 1'b0;
            in_access = 1'b0;
        end else if (in_access && !(psel && penable)) begin
            $display("psel or penable dropped during a wait state at %0t", $time);
            bus_faults++;
            in_access = 1'b0;
        end
        if (psel && !penable) begin
            cap_addr = paddr;
            cap_wdata = pwdata;
            cap_write = pwrite;
            waits = $random(seed) & 3;
            if (waits < min_wait) begin
                waits = min_wait;
            end
        end else if (psel && penable) begin
            if (paddr !== cap_addr || pwdata !== cap_wdata || pwrite !== cap_write) begin
                $display("APB address, data or direction changed mid-transfer at %0t", $time);
                bus_faults++;
            end
            if (waits == 0) begin
                pready = 1'b1;
                prdata = slave_mem[cap_addr[3:0]];
            end else begin
                waits--;
                in_access = 1'b1;
            end
        end else if (penable) begin
            $display("penable high without psel at %0t", $time);
            bus_faults++;
        end
    end

    task automatic check_value(input string what, input word_t got, input word_t expected);
        checks++;
        if (got !== expected) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    function automatic word_t encode_instr(input logic [4:0] op, input logic [2:0] rd,
                                           input logic [2:0] ra, input logic [4:0] low);
        return {op, rd, ra, low};
    endfunction

    function automatic word_t encode_movi(input logic [2:0] rd, input logic [7:0] imm);
        return {opc_movi, rd, imm};
    endfunction

    task automatic expect_transfer(input word_t addr, input word_t data, input logic write);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_write.push_back(write);
    endtask

    // the whole memory is written so nothing of an earlier program survives
    task automatic load_program();
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < instr_depth; i++) begin
            prog_we = 1'b1;
            prog_addr = i[instr_aw-1:0];
            prog_data = (i < prog.size()) ? prog[i] : 16'h0000;
            @(negedge clk);
        end
        prog_we = 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_value("psel in reset", {15'd0, psel}, 16'd0);
            check_value("penable in reset", {15'd0, penable}, 16'd0);
            check_value("pc in reset", {8'h00, pc}, 16'd0);
        end
    endtask

    task automatic run_program();
        int log_base;
        int fault_base;
        int n;
        int got;
        fault_base = bus_faults;
        load_program();
        log_base = log_addr.size();
        n = exp_addr.size();
        reset = 1'b0;
        while (log_addr.size() < log_base + n) begin
            @(negedge clk);
        end
        // the NOPs after the program must stay off the bus
        repeat (16) @(negedge clk);
        got = log_addr.size() - log_base;
        check_value("APB transfer count", 16'(got), 16'(n));
        for (int k = 0; k < n; k++) begin
            if (k < got) begin
                check_value($sformatf("transfer %0d paddr", k), log_addr[log_base + k],
                            exp_addr[k]);
                check_value($sformatf("transfer %0d data", k), log_data[log_base + k],
                            exp_data[k]);
                check_value($sformatf("transfer %0d pwrite", k),
                            {15'd0, log_write[log_base + k]}, {15'd0, exp_write[k]});
            end
        end
        check_value("APB protocol faults", 16'(bus_faults - fault_base), 16'd0);
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_write.delete();
    endtask

    task automatic reset_state_test();
        int err_base;
        err_base = errors;
        // registers come out of reset holding their own index
        prog.push_back(encode_movi(3'd0, 8'hc0));
        for (int r = 1; r < 8; r++) begin
            prog.push_back(encode_instr(opc_sw, r[2:0], 3'd0, 5'(r - 1)));
            expect_transfer(16'h00c0 + 16'(r - 1), 16'(r), 1'b1);
        end
        run_program();
        $display("test reset_state finished with %0d error(s)", errors - err_base);
    endtask

    // MOV r3 from a_reg, apply the operation with b_reg and store r3 at r6 + offset
    task automatic add_op_store(input logic [2:0] a_reg, input logic [2:0] b_reg,
                                input logic [4:0] op, input logic [4:0] fn,
                                input logic [4:0] offset, input word_t expected);
        prog.push_back(encode_instr(opc_mov, 3'd3, a_reg, 5'd0));
        prog.push_back(encode_instr(op, 3'd3, b_reg, fn));
        prog.push_back(encode_instr(opc_sw, 3'd3, 3'd6, offset));
        expect_transfer(16'h00d0 + {11'd0, offset}, expected, 1'b1);
    endtask

    task automatic alu_move_test();
        int err_base;
        word_t a;
        word_t b;
        word_t s;
        err_base = errors;
        a = 16'h00a5;
        b = 16'h003c;
        s = 16'd3;
        prog.push_back(encode_movi(3'd1, a[7:0]));
        prog.push_back(encode_movi(3'd2, b[7:0]));
        prog.push_back(encode_movi(3'd4, s[7:0]));
        prog.push_back(encode_movi(3'd6, 8'hd0));
        prog.push_back(encode_instr(opc_mov, 3'd3, 3'd1, 5'd0));
        prog.push_back(encode_instr(opc_sw, 3'd3, 3'd6, 5'd0));
        expect_transfer(16'h00d0, a, 1'b1);
        add_op_store(3'd1, 3'd2, opc_bit, fn_or, 5'd1, a | b);
        add_op_store(3'd1, 3'd2, opc_bit, fn_xor, 5'd2, a ^ b);
        add_op_store(3'd1, 3'd2, opc_bit, fn_and, 5'd3, a & b);
        add_op_store(3'd1, 3'd2, opc_bit, fn_not, 5'd4, ~b);
        add_op_store(3'd1, 3'd4, opc_bit, fn_lshft, 5'd5, a << s);
        add_op_store(3'd1, 3'd4, opc_bit, fn_rshft, 5'd6, a >> s);
        // shift by 60 clears the word
        add_op_store(3'd1, 3'd2, opc_bit, fn_lshft, 5'd7, 16'h0000);
        add_op_store(3'd1, 3'd2, opc_arith, fn_add, 5'd8, a + b);
        add_op_store(3'd2, 3'd1, opc_arith, fn_sub, 5'd9, b - a);
        run_program();
        $display("test alu_moves finished with %0d error(s)", errors - err_base);
    endtask

    task automatic scratch_memory_test();
        int err_base;
        err_base = errors;
        prog.push_back(encode_movi(3'd1, 8'h5a));
        prog.push_back(encode_movi(3'd2, 8'h10));
        prog.push_back(encode_instr(opc_sw, 3'd1, 3'd2, 5'd3));
        prog.push_back(encode_instr(opc_sw, 3'd7, 3'd2, 5'd4));
        prog.push_back(encode_instr(opc_lw, 3'd5, 3'd2, 5'd3));
        prog.push_back(encode_instr(opc_lw, 3'd3, 3'd2, 5'd4));
        prog.push_back(encode_movi(3'd6, 8'he0));
        prog.push_back(encode_instr(opc_sw, 3'd5, 3'd6, 5'd0));
        prog.push_back(encode_instr(opc_sw, 3'd3, 3'd6, 5'd1));
        expect_transfer(16'h00e0, 16'h005a, 1'b1);
        expect_transfer(16'h00e1, 16'h0007, 1'b1);
        run_program();
        $display("test scratch_memory finished with %0d error(s)", errors - err_base);
    endtask

    task automatic apb_read_test();
        int err_base;
        err_base = errors;
        slave_mem[1] = 16'h1234;
        slave_mem[2] = 16'hbeef;
        slave_mem[5] = 16'h0f0f;
        min_wait = 1;
        prog.push_back(encode_movi(3'd1, 8'h80));
        prog.push_back(encode_instr(opc_lw, 3'd2, 3'd1, 5'd1));
        prog.push_back(encode_instr(opc_lw, 3'd3, 3'd1, 5'd2));
        prog.push_back(encode_instr(opc_lw, 3'd4, 3'd1, 5'd5));
        prog.push_back(encode_instr(opc_sw, 3'd2, 3'd1, 5'd8));
        prog.push_back(encode_instr(opc_sw, 3'd3, 3'd1, 5'd9));
        prog.push_back(encode_instr(opc_sw, 3'd4, 3'd1, 5'd10));
        expect_transfer(16'h0081, 16'h1234, 1'b0);
        expect_transfer(16'h0082, 16'hbeef, 1'b0);
        expect_transfer(16'h0085, 16'h0f0f, 1'b0);
        expect_transfer(16'h0088, 16'h1234, 1'b1);
        expect_transfer(16'h0089, 16'hbeef, 1'b1);
        expect_transfer(16'h008a, 16'h0f0f, 1'b1);
        run_program();
        min_wait = 0;
        $display("test apb_reads finished with %0d error(s)", errors - err_base);
    endtask

    task automatic unknown_encoding_test();
        int err_base;
        err_base = errors;
        // opcode 31 is undefined so r3 must keep its reset value
        prog.push_back(encode_instr(5'h1f, 3'd3, 3'd7, 5'h1f));
        prog.push_back(encode_instr(opc_bit, 3'd4, 3'd1, 5'd7));
        prog.push_back(encode_instr(opc_arith, 3'd5, 3'd1, 5'd5));
        prog.push_back(encode_movi(3'd6, 8'hf0));
        prog.push_back(encode_instr(opc_sw, 3'd3, 3'd6, 5'd0));
        prog.push_back(encode_instr(opc_sw, 3'd4, 3'd6, 5'd1));
        prog.push_back(encode_instr(opc_sw, 3'd5, 3'd6, 5'd2));
        expect_transfer(16'h00f0, 16'h0003, 1'b1);
        expect_transfer(16'h00f1, 16'h0000, 1'b1);
        expect_transfer(16'h00f2, 16'h0000, 1'b1);
        run_program();
        $display("test unknown_encodings finished with %0d error(s)", errors - err_base);
    endtask

    initial begin
        reset = 1'b1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = 16'h0000;
        for (int i = 0; i < 16; i++) begin
            slave_mem[i] = 16'hc300 | 16'(i);
        end
        reset_state_test();
        alu_move_test();
        scratch_memory_test();
        apb_read_test();
        unknown_encoding_test();
        $display("tests run: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
